//--- uart_rx.f
uart_rx_pkg.sv
baud_gen.sv
rx_sequencer.sv
data_shifter.sv
frame_checker.sv
rx_combiner.sv
uart_rx.sv
tb_uart_rx.sv

//--- tb_uart_rx.sv
`timescale 1ns/1ns

module tb_uart_rx;

  import uart_rx_pkg::*;

  localparam int wait_limit = 15 * bit_period;  // Clocks allowed for one character

  logic       clk;
  logic       rstn;
  logic       rx;
  rx_result_t result;
  logic       valid;
  char_cnt_t  char_count;

  rx_result_t exp_q[$];      // Results still owed by the DUT, oldest first
  rx_result_t mon_exp;
  char_cnt_t  exp_count;     // Own model of the good character count
  int         err_count;
  int         err_mark;      // err_count when the current test began
  int         tests_passed;
  int         tests_failed;
  int         seed_val;

  uart_rx uart_rx_inst (
    .clk        (clk),
    .rstn       (rstn),
    .rx         (rx),
    .result     (result),
    .valid      (valid),
    .char_count (char_count)
  );

  always #10 clk = ~clk;  // 20 ns period

  // Expected result from the 8N1 framing rules
  function automatic rx_result_t expected_result(byte_t b, logic stop);
    rx_result_t r;
    r.data = b;
    if (stop)
      r.status = frm_ok;       // Good stop bit
    else if (b == 8'h00)
      r.status = frm_break;    // Low through the whole frame
    else
      r.status = frm_error;
    return r;
  endfunction

  task automatic check_result(rx_result_t got, rx_result_t exp);
    if (got !== exp) begin
      err_count++;
      $display("ERROR %0t: got data %h status %0d, expected data %h status %0d",
               $time, got.data, got.status, exp.data, exp.status);
    end
  endtask

  task automatic check_count(char_cnt_t got, char_cnt_t exp);
    if (got !== exp) begin
      err_count++;
      $display("ERROR %0t: char_count %0d, expected %0d", $time, got, exp);
    end
  endtask

  // Compare every strobe against the queue, sampled mid cycle
  always @(negedge clk) begin
    if (rstn && valid) begin
      if (exp_q.size() == 0) begin
        err_count++;
        $display("ERROR %0t: result strobe while no character was sent", $time);
      end else begin
        mon_exp = exp_q.pop_front();
        check_result(result, mon_exp);
      end
    end
  end

  // Line level for a whole number of clocks, changed just after the edge
  task automatic hold_line(logic level, int clocks);
    @(posedge clk);
    #1;
    rx = level;
    repeat (clocks - 1) @(posedge clk);
  endtask

  // Start bit, eight data bits LSB first, stop bit, then idle high
  task automatic send_frame(byte_t b, logic stop, int gap);
    hold_line(1'b0, bit_period);
    for (int i = 0; i < 8; i++)
      hold_line(b[i], bit_period);
    hold_line(stop, bit_period);
    if (gap > 0)
      hold_line(1'b1, gap);
  endtask

  // Queue the expected result, update the count model, then drive the frame
  task automatic send_checked(byte_t b, logic stop, int gap);
    rx_result_t r;
    r = expected_result(b, stop);
    exp_q.push_back(r);
    if (r.status == frm_ok)
      exp_count++;
    send_frame(b, stop, gap);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rstn = 1'b0;
    rx   = 1'b1;            // Idle line
    repeat (2) @(posedge clk);
    #1;
    rstn = 1'b1;
    exp_q.delete();
    exp_count = '0;
  endtask

  // Wait until every queued character has come out
  task automatic wait_results();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < wait_limit) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      err_count++;
      $display("Timeout at %0t: no character arrived within 15 bit periods, %0d missing",
               $time, exp_q.size());
      exp_q.delete();
    end
    @(negedge clk);         // Count settles with the strobe
  endtask

  // Line must stay silent for the full timeout
  task automatic expect_quiet();
    int cycles;
    int strobes;
    cycles  = 0;
    strobes = 0;
    while (cycles < wait_limit) begin
      @(negedge clk);
      if (valid)
        strobes++;
      cycles++;
    end
    if (strobes != 0) begin
      err_count++;
      $display("Quiet line at %0t gave %0d result strobes instead of none", $time, strobes);
    end
  endtask

  task automatic end_test(string name);
    if (err_count == err_mark) begin
      tests_passed++;
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, err_count - err_mark);
    end
    err_mark = err_count;
  endtask

  initial begin
    clk          = 1'b0;
    rstn         = 1'b0;
    rx           = 1'b1;
    exp_count    = '0;
    err_count    = 0;
    err_mark     = 0;
    tests_passed = 0;
    tests_failed = 0;
    seed_val     = $urandom(8179);  // Seed once for the whole run
    apply_reset();
    @(negedge clk);
    check_count(char_count, 8'd0);

    // Directed bytes, LSB first ordering
    send_checked(8'h00, 1'b1, 4);
    send_checked(8'hFF, 1'b1, 4);
    send_checked(8'h55, 1'b1, 4);
    send_checked(8'hA5, 1'b1, 4);
    wait_results();
    check_count(char_count, exp_count);
    end_test("directed bytes");

    // Back to back random traffic, one idle clock between frames
    for (int n = 0; n < 40; n++)
      send_checked(byte_t'($urandom()), 1'b1, 1);
    wait_results();
    check_count(char_count, exp_count);
    end_test("random back to back");

    // Missing stop bit with data, the tail of the stop bit is a false start
    send_checked(8'h3C, 1'b0, bit_period);
    wait_results();
    check_count(char_count, exp_count);
    end_test("framing error");

    send_checked(8'h00, 1'b0, bit_period);
    wait_results();
    check_count(char_count, exp_count);
    end_test("break");

    // Short low pulse is rejected at the start bit centre
    hold_line(1'b0, half_period / 2);
    hold_line(1'b1, 1);
    expect_quiet();
    send_checked(8'h96, 1'b1, 4);
    wait_results();
    check_count(char_count, exp_count);
    end_test("glitch rejection");

    // Reset in the middle of a frame
    hold_line(1'b0, bit_period);
    hold_line(1'b1, bit_period);
    apply_reset();
    @(negedge clk);
    check_count(char_count, 8'd0);
    expect_quiet();
    send_checked(8'hC3, 1'b1, 4);
    wait_results();
    check_count(char_count, exp_count);
    end_test("mid-run reset");

    $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
             err_count);
    if (err_count == 0 && tests_failed == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- uart_rx.sv
`timescale 1ns/1ns

module uart_rx (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    rx,          // Asynchronous serial line
  output uart_rx_pkg::rx_result_t result,      // Byte and frame status
  output logic                    valid,       // Result strobe
  output uart_rx_pkg::char_cnt_t  char_count   // Good characters received
);

  import uart_rx_pkg::*;

  logic          rx_meta;  // First synchronizer stage
  logic          rx_sync;  // Line as seen by the receiver
  logic          tick;
  logic          restart;
  logic          done;
  rx_slot_t      slot;
  byte_t         data;
  frame_status_e status;

  // Two flop synchronizer, idles high like the line
  always_ff @(posedge clk) begin
    if (!rstn) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  baud_gen baud_gen_inst (
    .clk     (clk),
    .rstn    (rstn),
    .restart (restart),
    .tick    (tick)
  );

  rx_sequencer rx_sequencer_inst (
    .clk     (clk),
    .rstn    (rstn),
    .rx      (rx_sync),
    .tick    (tick),
    .restart (restart),
    .slot    (slot),
    .done    (done)
  );

  // Shifter and checker run side by side on the same slots
  data_shifter data_shifter_inst (
    .clk  (clk),
    .rstn (rstn),
    .rx   (rx_sync),
    .slot (slot),
    .data (data)
  );

  frame_checker frame_checker_inst (
    .clk    (clk),
    .rstn   (rstn),
    .rx     (rx_sync),
    .slot   (slot),
    .status (status)
  );

  rx_combiner rx_combiner_inst (
    .clk        (clk),
    .rstn       (rstn),
    .done       (done),
    .data       (data),
    .status     (status),
    .result     (result),
    .valid      (valid),
    .char_count (char_count)
  );

endmodule

//--- rx_combiner.sv
`timescale 1ns/1ns

module rx_combiner (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       done,        // Frame complete from the sequencer
  input  uart_rx_pkg::byte_t         data,        // Assembled byte
  input  uart_rx_pkg::frame_status_e status,      // Frame verdict
  output uart_rx_pkg::rx_result_t    result,
  output logic                       valid,       // One clock strobe, no handshake
  output uart_rx_pkg::char_cnt_t     char_count   // Good characters only
);

  import uart_rx_pkg::*;

  logic good;  // This frame counts

  assign good = done && (status == frm_ok);

  // Result register, loaded once per frame
  always_ff @(posedge clk) begin
    if (!rstn) begin
      result.data   <= '1;      // Idle line value
      result.status <= frm_ok;
    end else if (done) begin
      result.data   <= data;
      result.status <= status;
    end
  end

  // Strobe lines up with the freshly loaded result
  always_ff @(posedge clk) begin
    if (!rstn)
      valid <= 1'b0;
    else
      valid <= done;
  end

  // Debug style character counter, wraps silently
  always_ff @(posedge clk) begin
    if (!rstn)
      char_count <= '0;
    else if (good)
      char_count <= char_count + 1'b1;
  end

endmodule

//--- frame_checker.sv
`timescale 1ns/1ns

module frame_checker (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        rx,      // Synchronized serial line
  input  uart_rx_pkg::rx_slot_t       slot,    // Tagged tick from the sequencer
  output uart_rx_pkg::frame_status_e  status   // Held until the next stop tick
);

  import uart_rx_pkg::*;

  logic seen_one;  // Some data bit was high in this frame
  logic start_tick;
  logic data_tick;
  logic stop_tick;

  assign start_tick = slot.tick && (slot.kind == slot_start);
  assign data_tick  = slot.tick && (slot.kind == slot_data);
  assign stop_tick  = slot.tick && (slot.kind == slot_stop);

  // Sticky flag over the data slots
  always_ff @(posedge clk) begin
    if (!rstn)
      seen_one <= 1'b0;
    else if (start_tick)
      seen_one <= 1'b0;       // New frame
    else if (data_tick && rx)
      seen_one <= 1'b1;
  end

  // Judge the frame at the stop bit centre
  always_ff @(posedge clk) begin
    if (!rstn) begin
      status <= frm_ok;
    end else if (stop_tick) begin
      if (rx)
        status <= frm_ok;       // Proper stop bit
      else if (!seen_one)
        status <= frm_break;    // Low from start to stop
      else
        status <= frm_error;    // Missing stop bit
    end
  end

endmodule

//--- data_shifter.sv
`timescale 1ns/1ns

module data_shifter (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  rx,    // Synchronized serial line
  input  uart_rx_pkg::rx_slot_t slot,  // Tagged tick from the sequencer
  output uart_rx_pkg::byte_t    data   // First received bit ends in bit 0
);

  import uart_rx_pkg::*;

  logic data_tick;  // Centre of a data bit

  assign data_tick = slot.tick && (slot.kind == slot_data);

  // Right shift, new bit enters at the MSB
  always_ff @(posedge clk) begin
    if (!rstn)
      data <= '1;                // Idle line value
    else if (data_tick)
      data <= {rx, data[7:1]};
  end

endmodule

//--- rx_sequencer.sv
`timescale 1ns/1ns

module rx_sequencer (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  rx,       // Synchronized serial line
  input  logic                  tick,     // Bit centre pulse from the divider
  output logic                  restart,  // Holds the divider while not receiving
  output uart_rx_pkg::rx_slot_t slot,     // Tagged tick to shifter and checker
  output logic                  done      // Frame complete, one clock
);

  import uart_rx_pkg::*;

  rx_state_e state;
  bit_idx_t  idx;     // Current slot, 0 start .. 9 stop
  logic      false_start;
  slot_e     kind;

  // Start bit gone high again at its centre means a glitch
  assign false_start = (idx == 4'd0) && rx;

  // Slot kind from the index
  always_comb begin
    if (idx == 4'd0)
      kind = slot_start;
    else if (idx <= 4'd8)
      kind = slot_data;
    else
      kind = slot_stop;
  end

  always_comb begin
    slot.tick = 1'b0;
    slot.kind = slot_none;
    if (state == st_receive && tick && !false_start) begin
      slot.tick = 1'b1;
      slot.kind = kind;
    end
  end

  assign restart = (state != st_receive);  // Divider runs only while receiving
  assign done    = (state == st_finish);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= st_idle;
      idx   <= '0;
    end else begin
      case (state)
        st_idle: begin
          idx <= '0;
          if (!rx)
            state <= st_receive;  // Falling edge of the start bit
        end
        st_receive: begin
          if (tick) begin
            if (false_start)
              state <= st_idle;   // Glitch, drop it silently
            else if (idx == 4'd9)
              state <= st_finish;  // Stop bit sampled
            else
              idx <= idx + 1'b1;
          end
        end
        st_finish: begin
          state <= st_idle;  // Rest of the stop bit is spent in idle
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

//--- baud_gen.sv
`timescale 1ns/1ns

module baud_gen (
  input  logic clk,
  input  logic rstn,
  input  logic restart,  // Level, holds the divider at zero
  output logic tick      // One clock pulse at each bit centre
);

  import uart_rx_pkg::*;

  baud_cnt_t cnt;
  logic      first;  // Still timing the half period after restart
  logic      at_end;

  // First period is only half a bit, so ticks sit at bit centres
  always_comb begin
    if (first)
      at_end = (cnt == baud_cnt_t'(half_period - 1));
    else
      at_end = (cnt == baud_cnt_t'(bit_period - 1));
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt   <= '0;
      first <= 1'b1;
      tick  <= 1'b0;
    end else if (restart) begin
      cnt   <= '0;     // Held at zero while idle
      first <= 1'b1;   // Rearm the half period
      tick  <= 1'b0;
    end else if (at_end) begin
      cnt   <= '0;     // Wrap
      first <= 1'b0;   // Full bit periods from here on
      tick  <= 1'b1;
    end else begin
      cnt  <= cnt + 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

//--- uart_rx_pkg.sv
package uart_rx_pkg;

  // Baud timing in system clocks, 115200 baud at 12 MHz
  localparam int bit_period  = 104;  // Clocks per serial bit
  localparam int half_period = 52;   // Restart to first tick, lands mid start bit

  // Plain vector types
  typedef logic [6:0] baud_cnt_t;  // Divider count, holds up to bit_period-1
  typedef logic [7:0] byte_t;      // One data byte
  typedef logic [7:0] char_cnt_t;  // Good character count, wraps
  typedef logic [3:0] bit_idx_t;   // Slot index 0..9 inside a frame

  // Kind of bit slot a tick falls in
  typedef enum logic [1:0] {
    slot_none,   // No tick this clock
    slot_start,  // Slot 0, start bit centre
    slot_data,   // Slots 1..8, data bits LSB first
    slot_stop    // Slot 9, stop bit centre
  } slot_e;

  // Per-cycle timing word from the sequencer
  typedef struct packed {
    logic  tick;  // Sample the line now
    slot_e kind;
  } rx_slot_t;

  // Receiver FSM states
  typedef enum logic [1:0] {
    st_idle,     // Divider held, waiting for a start edge
    st_receive,  // Walking through the ten slots
    st_finish    // One clock, frame done
  } rx_state_e;

  typedef enum logic [1:0] {
    frm_ok,     // Stop bit high
    frm_error,  // Stop bit low with some data
    frm_break   // Line held low for the whole frame
  } frame_status_e;

  // Result word handed to the consumer
  typedef struct packed {
    byte_t         data;
    frame_status_e status;
  } rx_result_t;

endpackage
